// File: logic/video_pkg.sv
// Video shared definitions
`default_nettype none

package video_pkg;

	// ----------------------------------------
	// line and frame timing, in clk_reg cycles
	// ----------------------------------------
	localparam int LINE_CYCLES   = 456;
	localparam int FRAME_LINES   = 154;
	localparam int VISIBLE_LINES = 144;
	localparam int OAM_CYCLES    = 80;
	localparam int DRAW_CYCLES   = 172;
	// output window start, after the last tile fetch
	localparam int OUT_START     = 250;
	localparam int LINE_PIXELS   = 160;

	// meaningful widths
	typedef logic [8:0]  hcnt_t;
	typedef logic [7:0]  line_t;
	typedef logic [12:0] vram_addr_t;
	typedef logic [7:0]  byte_t;
	// raw colour index or palette shade
	typedef logic [1:0]  shade_t;

	// ----------------------------------------
	// cpu register addresses
	// ----------------------------------------
	localparam byte_t ADDR_LCDC = 8'h40;
	localparam byte_t ADDR_STAT = 8'h41;
	localparam byte_t ADDR_SCY  = 8'h42;
	localparam byte_t ADDR_SCX  = 8'h43;
	localparam byte_t ADDR_LY   = 8'h44;
	localparam byte_t ADDR_LYC  = 8'h45;
	localparam byte_t ADDR_DMA  = 8'h46;
	localparam byte_t ADDR_BGP  = 8'h47;
	localparam byte_t ADDR_OBP0 = 8'h48;
	localparam byte_t ADDR_OBP1 = 8'h49;
	localparam byte_t ADDR_WY   = 8'h4A;
	localparam byte_t ADDR_WX   = 8'h4B;

	// stat mode field encoding
	typedef enum logic [1:0] {
		MODE_HBLANK = 2'd0,
		MODE_VBLANK = 2'd1,
		MODE_OAM    = 2'd2,
		MODE_DRAW   = 2'd3
	} lcd_mode_t;

	// register fields seen by timing, fetch and output
	typedef struct packed {
		logic  lcdc_on;
		logic  bg_map_sel;
		logic  tile_data_sel;
		logic  bg_ena;
		logic  stat_lyc_ie;
		logic  stat_oam_ie;
		logic  stat_vblank_ie;
		logic  stat_hblank_ie;
		byte_t scx;
		byte_t scy;
		byte_t lyc;
		byte_t bgp;
	} lcd_regs_t;

endpackage

`default_nettype wire

// File: logic/video_regs.sv
// Video CPU register file
`timescale 1ns/1ps
`default_nettype none

module video_regs import video_pkg::*; (
	input  wire       clk_reg,
	input  wire       reset,
	input  wire       sel_reg,
	input  wire       wr,
	input  byte_t     addr,
	input  byte_t     di,
	input  line_t     ly,
	input  lcd_mode_t mode,
	input  wire       lyc_match,
	output lcd_regs_t regs,
	output byte_t     dout
);

	// full lcdc byte, all bits read back
	byte_t lcdc;
	// stat bits 6..3, the interrupt enables
	logic [3:0] stat_ie;
	byte_t scy;
	byte_t scx;
	byte_t lyc;
	byte_t bgp;
	// window position, stored for readback only
	byte_t wy;
	byte_t wx;

	logic wr_en;

	assign wr_en = sel_reg && wr;

	// ----------------------------------------
	// write decode
	// ----------------------------------------
	always_ff @(posedge clk_reg) begin
		if (reset) begin
			lcdc    <= 8'h00;
			stat_ie <= 4'h0;
			scy     <= 8'h00;
			scx     <= 8'h00;
			lyc     <= 8'h00;
			// dmg boot palette
			bgp     <= 8'hFC;
			wy      <= 8'h00;
			wx      <= 8'h00;
		end else if (wr_en) begin
			// ly is owned by the line counter, dma is gone
			case (addr)
				ADDR_LCDC: lcdc    <= di;
				ADDR_STAT: stat_ie <= di[6:3];
				ADDR_SCY:  scy     <= di;
				ADDR_SCX:  scx     <= di;
				ADDR_LYC:  lyc     <= di;
				ADDR_BGP:  bgp     <= di;
				ADDR_WY:   wy      <= di;
				ADDR_WX:   wx      <= di;
				default: ;
			endcase
		end
	end

	// bundle for the rest of the video block
	assign regs.lcdc_on        = lcdc[7];
	assign regs.tile_data_sel  = lcdc[4];
	assign regs.bg_map_sel     = lcdc[3];
	assign regs.bg_ena         = lcdc[0];
	assign regs.stat_lyc_ie    = stat_ie[3];
	assign regs.stat_oam_ie    = stat_ie[2];
	assign regs.stat_vblank_ie = stat_ie[1];
	assign regs.stat_hblank_ie = stat_ie[0];
	assign regs.scx            = scx;
	assign regs.scy            = scy;
	assign regs.lyc            = lyc;
	assign regs.bgp            = bgp;

	// ----------------------------------------
	// read mux, combinational from addr
	// ----------------------------------------
	always_comb begin
		case (addr)
			ADDR_LCDC: dout = lcdc;
			// bit 7 always reads as one
			ADDR_STAT: dout = {1'b1, stat_ie, lyc_match, mode};
			ADDR_SCY:  dout = scy;
			ADDR_SCX:  dout = scx;
			ADDR_LY:   dout = ly;
			ADDR_LYC:  dout = lyc;
			ADDR_BGP:  dout = bgp;
			ADDR_WY:   dout = wy;
			ADDR_WX:   dout = wx;
			// no dma and no sprite palettes in this block
			ADDR_DMA, ADDR_OBP0, ADDR_OBP1: dout = 8'hFF;
			default:   dout = 8'hFF;
		endcase
	end

endmodule

`default_nettype wire

// File: logic/video_timing.sv
// Video line and frame timing
`timescale 1ns/1ps
`default_nettype none

module video_timing import video_pkg::*; (
	input  wire       clk_reg,
	input  wire       reset,
	input  lcd_regs_t regs,
	output hcnt_t     h_cnt,
	output line_t     ly,
	output lcd_mode_t mode,
	output logic      lyc_match,
	output logic      line_end,
	output logic      irq,
	output logic      vblank_irq
);

	localparam hcnt_t LAST_CYCLE = hcnt_t'(LINE_CYCLES - 1);
	localparam line_t LAST_LINE  = line_t'(FRAME_LINES - 1);
	// first cycle of hblank on a visible line
	localparam hcnt_t HBLANK_START = hcnt_t'(OAM_CYCLES + DRAW_CYCLES);

	logic visible;
	logic vblank_cond;
	logic line_start;
	logic irq_cond;

	// ----------------------------------------
	// line and frame counters
	// ----------------------------------------
	always_ff @(posedge clk_reg) begin
		if (reset || !regs.lcdc_on) begin
			// held at the top left while the display is off
			h_cnt <= '0;
			ly    <= '0;
		end else if (h_cnt == LAST_CYCLE) begin
			h_cnt <= '0;
			if (ly == LAST_LINE)
				ly <= '0;
			else
				ly <= ly + 8'd1;
		end else begin
			h_cnt <= h_cnt + 9'd1;
		end
	end

	assign visible   = (ly < line_t'(VISIBLE_LINES));
	assign line_end  = regs.lcdc_on && (h_cnt == LAST_CYCLE);
	// h_cnt also sits at 0 when off, so gate with lcdc_on
	assign line_start = regs.lcdc_on && (h_cnt == '0);
	assign lyc_match = (ly == regs.lyc);

	// mode straight from the counters
	always_comb begin
		if (!regs.lcdc_on)
			mode = MODE_HBLANK;
		else if (!visible)
			mode = MODE_VBLANK;
		else if (h_cnt < hcnt_t'(OAM_CYCLES))
			mode = MODE_OAM;
		else if (h_cnt < HBLANK_START)
			mode = MODE_DRAW;
		else
			mode = MODE_HBLANK;
	end

	// ----------------------------------------
	// interrupts
	// ----------------------------------------

	// last cycle of line 143
	assign vblank_cond = line_end && (ly == line_t'(VISIBLE_LINES - 1));

	// any enabled stat source
	assign irq_cond =
		(regs.stat_lyc_ie    && line_start && lyc_match) ||
		(regs.stat_oam_ie    && line_start && visible) ||
		(regs.stat_vblank_ie && vblank_cond) ||
		(regs.stat_hblank_ie && regs.lcdc_on && visible && (h_cnt == HBLANK_START));

	// one cycle after the condition, one cycle wide
	always_ff @(posedge clk_reg) begin
		if (reset) begin
			irq        <= 1'b0;
			vblank_irq <= 1'b0;
		end else begin
			irq        <= irq_cond;
			vblank_irq <= vblank_cond;
		end
	end

endmodule

`default_nettype wire

// File: logic/bg_fetch.sv
// Background tile fetcher
`timescale 1ns/1ps
`default_nettype none

module bg_fetch import video_pkg::*; (
	input  wire        clk_reg,
	input  wire        reset,
	input  lcd_regs_t  regs,
	input  hcnt_t      h_cnt,
	input  line_t      ly,
	input  wire        line_end,
	input  byte_t      vram_data,
	output logic       vram_rd,
	output vram_addr_t vram_addr,
	output shade_t     pix,
	output logic       pix_valid
);

	// 21 groups of 8 cycles, from the end of oam search
	localparam int    FETCH_GROUPS = 21;
	localparam hcnt_t FETCH_END    = hcnt_t'(OAM_CYCLES + FETCH_GROUPS * 8);
	// pixels leave one group behind the fetch
	localparam hcnt_t STREAM_START = hcnt_t'(OAM_CYCLES + 8);
	localparam hcnt_t STREAM_END   = hcnt_t'(FETCH_END + 8);
	// scroll latch, just ahead of mode 3
	localparam hcnt_t LATCH_CYCLE  = hcnt_t'(OAM_CYCLES - 2);

	logic       fetch_win;
	logic       stream;
	logic [2:0] phase;

	// per-line state
	line_t      bg_line;
	logic [4:0] map_col;
	logic [2:0] skip_cnt;
	logic [7:0] pix_cnt;

	// fetched bytes and shifters
	byte_t tile_num;
	byte_t data_lo;
	byte_t data_hi;
	byte_t shift_lo;
	byte_t shift_hi;

	logic tile_a12;

	assign fetch_win = regs.lcdc_on && (ly < line_t'(VISIBLE_LINES)) &&
		(h_cnt >= hcnt_t'(OAM_CYCLES)) && (h_cnt < FETCH_END);
	assign stream = regs.lcdc_on && (ly < line_t'(VISIBLE_LINES)) &&
		(h_cnt >= STREAM_START) && (h_cnt < STREAM_END);
	// fetch starts on a multiple of 8
	assign phase = h_cnt[2:0];

	// ----------------------------------------
	// vram addressing
	// ----------------------------------------

	// 0/1 map, 2/3 low byte, 4/5 high byte, 6/7 idle
	assign vram_rd = fetch_win && (phase[2:1] != 2'b11);

	// signed tile numbers sit around 0x1000
	assign tile_a12 = !regs.tile_data_sel && !tile_num[7];

	always_comb begin
		case (phase[2:1])
			2'b01:   vram_addr = {tile_a12, tile_num, bg_line[2:0], 1'b0};
			2'b10:   vram_addr = {tile_a12, tile_num, bg_line[2:0], 1'b1};
			// map base 0x1800 or 0x1C00
			default: vram_addr = {2'b11, regs.bg_map_sel, bg_line[7:3], map_col};
		endcase
	end

	// ----------------------------------------
	// line setup and pixel count
	// ----------------------------------------
	always_ff @(posedge clk_reg) begin
		if (reset) begin
			bg_line  <= '0;
			map_col  <= '0;
			skip_cnt <= '0;
			pix_cnt  <= '0;
		end else begin
			if (h_cnt == LATCH_CYCLE) begin
				bg_line  <= ly + regs.scy;
				map_col  <= regs.scx[7:3];
				skip_cnt <= regs.scx[2:0];
			end else if (fetch_win && phase == 3'd7) begin
				// next tile, wraps within the 32-wide map
				map_col <= map_col + 5'd1;
			end
			// fine scroll drops the leading pixels
			if (stream && skip_cnt != 3'd0)
				skip_cnt <= skip_cnt - 3'd1;
			if (line_end || !regs.lcdc_on)
				pix_cnt <= '0;
			else if (pix_valid)
				pix_cnt <= pix_cnt + 8'd1;
		end
	end

	// ----------------------------------------
	// data capture and shift-out
	// ----------------------------------------
	always_ff @(posedge clk_reg) begin
		// data arrives the cycle after the read
		if (fetch_win) begin
			if (phase == 3'd1)
				tile_num <= vram_data;
			if (phase == 3'd3)
				data_lo <= vram_data;
			if (phase == 3'd5)
				data_hi <= vram_data;
		end
		if (fetch_win && phase == 3'd7) begin
			shift_lo <= data_lo;
			shift_hi <= data_hi;
		end else begin
			shift_lo <= {shift_lo[6:0], 1'b0};
			shift_hi <= {shift_hi[6:0], 1'b0};
		end
	end

	// leftmost pixel is the msb
	assign pix = {shift_hi[7], shift_lo[7]};
	assign pix_valid = stream && (skip_cnt == 3'd0) && (pix_cnt < 8'(LINE_PIXELS));

endmodule

`default_nettype wire

// File: logic/pixel_out.sv
// Palette and line output
`timescale 1ns/1ps
`default_nettype none

module pixel_out import video_pkg::*; (
	input  wire       clk_reg,
	input  wire       reset,
	input  lcd_regs_t regs,
	input  hcnt_t     h_cnt,
	input  line_t     ly,
	input  wire       line_end,
	input  shade_t    pix,
	input  wire       pix_valid,
	output logic      lcd_on,
	output logic      lcd_clkena,
	output shade_t    lcd_data
);

	// registered outputs, so look one cycle ahead
	localparam hcnt_t RD_FIRST = hcnt_t'(OUT_START - 1);
	localparam hcnt_t RD_END   = hcnt_t'(OUT_START + LINE_PIXELS - 1);

	// one line of raw colour indices
	shade_t     line_buf [LINE_PIXELS];
	logic [7:0] wptr;
	logic [7:0] rptr;
	logic       rd_win;
	shade_t     raw;
	shade_t     shade;

	// ----------------------------------------
	// buffer write side
	// ----------------------------------------
	always_ff @(posedge clk_reg) begin
		if (reset || line_end)
			wptr <= '0;
		else if (pix_valid)
			wptr <= wptr + 8'd1;
	end

	always_ff @(posedge clk_reg) begin
		if (pix_valid)
			line_buf[wptr] <= pix;
	end

	// ----------------------------------------
	// read side and palette
	// ----------------------------------------
	assign rd_win = regs.lcdc_on && (ly < line_t'(VISIBLE_LINES)) &&
		(h_cnt >= RD_FIRST) && (h_cnt < RD_END);
	assign rptr = 8'(h_cnt - RD_FIRST);
	assign raw = line_buf[rptr];
	// bgp holds two bits per colour index, background off gives shade 0
	assign shade = regs.bg_ena ? regs.bgp[{raw, 1'b0} +: 2] : 2'd0;

	always_ff @(posedge clk_reg) begin
		if (reset)
			lcd_clkena <= 1'b0;
		else
			lcd_clkena <= rd_win;
	end

	always_ff @(posedge clk_reg) begin
		lcd_data <= shade;
	end

	assign lcd_on = regs.lcdc_on;

endmodule

`default_nettype wire

// File: logic/video.sv
// Background video top level
`timescale 1ns/1ps
`default_nettype none

module video import video_pkg::*; (
	input  wire        clk_reg,
	input  wire        reset,
	// cpu register port
	input  wire        sel_reg,
	input  wire        wr,
	input  byte_t      addr,
	input  byte_t      di,
	output byte_t      dout,
	// vram port, data one cycle after the read
	output logic       vram_rd,
	output vram_addr_t vram_addr,
	input  byte_t      vram_data,
	// lcd side
	output logic       lcd_on,
	output logic       lcd_clkena,
	output shade_t     lcd_data,
	output logic       irq,
	output logic       vblank_irq,
	output lcd_mode_t  mode
);

	lcd_regs_t regs;
	hcnt_t     h_cnt;
	line_t     ly;
	logic      lyc_match;
	logic      line_end;
	shade_t    pix;
	logic      pix_valid;

	// ----------------------------------------
	// cpu registers and timing
	// ----------------------------------------
	video_regs u_regs (
		.clk_reg   (clk_reg),
		.reset     (reset),
		.sel_reg   (sel_reg),
		.wr        (wr),
		.addr      (addr),
		.di        (di),
		.ly        (ly),
		.mode      (mode),
		.lyc_match (lyc_match),
		.regs      (regs),
		.dout      (dout)
	);

	video_timing u_timing (
		.clk_reg    (clk_reg),
		.reset      (reset),
		.regs       (regs),
		.h_cnt      (h_cnt),
		.ly         (ly),
		.mode       (mode),
		.lyc_match  (lyc_match),
		.line_end   (line_end),
		.irq        (irq),
		.vblank_irq (vblank_irq)
	);

	// ----------------------------------------
	// pixel path
	// ----------------------------------------
	bg_fetch u_fetch (
		.clk_reg   (clk_reg),
		.reset     (reset),
		.regs      (regs),
		.h_cnt     (h_cnt),
		.ly        (ly),
		.line_end  (line_end),
		.vram_data (vram_data),
		.vram_rd   (vram_rd),
		.vram_addr (vram_addr),
		.pix       (pix),
		.pix_valid (pix_valid)
	);

	pixel_out u_out (
		.clk_reg    (clk_reg),
		.reset      (reset),
		.regs       (regs),
		.h_cnt      (h_cnt),
		.ly         (ly),
		.line_end   (line_end),
		.pix        (pix),
		.pix_valid  (pix_valid),
		.lcd_on     (lcd_on),
		.lcd_clkena (lcd_clkena),
		.lcd_data   (lcd_data)
	);

endmodule

`default_nettype wire

// File: bench/video_assertions.sv
// Video timing assertions
`timescale 1ns/1ps
`default_nettype none

module video_assertions import video_pkg::*; (
	input wire       clk_reg,
	input wire       reset,
	input wire       lcd_on,
	input wire       lcd_clkena,
	input wire       irq,
	input wire       vblank_irq,
	input lcd_mode_t mode
);

	// no output during the vertical blank
	assert property (@(posedge clk_reg) disable iff (reset)
		(mode == MODE_VBLANK) |-> !lcd_clkena)
		else $error("lcd_clkena high in vblank");

	// both interrupts are single-cycle pulses
	assert property (@(posedge clk_reg) disable iff (reset)
		irq |=> !irq)
		else $error("irq longer than one cycle");

	assert property (@(posedge clk_reg) disable iff (reset)
		vblank_irq |=> !vblank_irq)
		else $error("vblank_irq longer than one cycle");

	// drawing mode needs the display on
	assert property (@(posedge clk_reg) disable iff (reset)
		!lcd_on |-> (mode != MODE_DRAW))
		else $error("mode 3 with display off");

endmodule

bind video video_assertions u_assert (
	.clk_reg    (clk_reg),
	.reset      (reset),
	.lcd_on     (lcd_on),
	.lcd_clkena (lcd_clkena),
	.irq        (irq),
	.vblank_irq (vblank_irq),
	.mode       (mode)
);

`default_nettype wire

// File: bench/video_tb.sv
// Video testbench
`timescale 1ns/1ps
`default_nettype none

module video_tb;
	import video_pkg::*;

	logic       clk_reg;
	logic       reset;
	logic       sel_reg;
	logic       wr;
	byte_t      addr;
	byte_t      di;
	byte_t      dout;
	logic       vram_rd;
	vram_addr_t vram_addr;
	byte_t      vram_data;
	logic       lcd_on;
	logic       lcd_clkena;
	shade_t     lcd_data;
	logic       irq;
	logic       vblank_irq;
	lcd_mode_t  mode;

	// 8K byte vram image
	byte_t vram_mem [8192];
	integer seed;
	int err_cnt;
	int chk_cnt;
	int irq_cnt;
	int vb_cnt;

	// comparator state and active register setup
	logic   check_on;
	logic   prev_clkena;
	int     chk_line;
	int     chk_col;
	shade_t exp_shade;
	byte_t  cfg_lcdc;
	byte_t  cfg_scx;
	byte_t  cfg_scy;
	byte_t  cfg_bgp;

	video dut (.*);

	always #5 clk_reg = ~clk_reg;

	// read data one cycle after the request
	always @(posedge clk_reg) begin
		if (vram_rd)
			vram_data <= vram_mem[vram_addr];
	end

	// ----------------------------------------
	// reference model
	// ----------------------------------------
	function automatic shade_t ref_pixel(int line, int col, byte_t lcdc, byte_t scx,
		byte_t scy, byte_t bgp);
		byte_t bgy;
		byte_t bgx;
		byte_t tile;
		int    tnum;
		int    map_addr;
		int    tile_addr;
		int    bit_pos;
		int    idx;
		bgy = 8'(line + int'(scy));
		bgx = 8'(col + int'(scx));
		map_addr = 'h1800 + (lcdc[3] ? 'h400 : 0) + int'(bgy[7:3]) * 32 + int'(bgx[7:3]);
		tile = vram_mem[map_addr];
		tnum = int'(tile);
		// signed tile numbers around 0x1000
		if (!lcdc[4] && tnum >= 128)
			tnum = tnum - 256;
		tile_addr = (lcdc[4] ? 0 : 'h1000) + tnum * 16 + int'(bgy[2:0]) * 2;
		bit_pos = 7 - int'(bgx[2:0]);
		idx = int'(vram_mem[tile_addr + 1][bit_pos]) * 2 + int'(vram_mem[tile_addr][bit_pos]);
		if (!lcdc[0])
			return 2'd0;
		return shade_t'((bgp >> (idx * 2)) & 8'h03);
	endfunction

	// ----------------------------------------
	// comparing process
	// ----------------------------------------
	always @(negedge clk_reg) begin
		if (check_on) begin
			if (lcd_clkena) begin
				exp_shade = ref_pixel(chk_line, chk_col, cfg_lcdc, cfg_scx, cfg_scy, cfg_bgp);
				chk_cnt = chk_cnt + 1;
				if (lcd_data !== exp_shade) begin
					err_cnt = err_cnt + 1;
					$display("Fail t=%0t lcd_data line %0d col %0d exp=%0d got=%0d",
						$time, chk_line, chk_col, exp_shade, lcd_data);
				end
				chk_col = chk_col + 1;
			end else if (prev_clkena) begin
				// end of one output burst
				chk_cnt = chk_cnt + 1;
				if (chk_col != LINE_PIXELS) begin
					err_cnt = err_cnt + 1;
					$display("Fail t=%0t lcd_clkena cycles exp=%0d got=%0d",
						$time, LINE_PIXELS, chk_col);
				end
				chk_line = chk_line + 1;
				chk_col = 0;
			end
		end
		prev_clkena = lcd_clkena;
	end

	// interrupt pulse counters
	always @(negedge clk_reg) begin
		if (irq)
			irq_cnt = irq_cnt + 1;
		if (vblank_irq)
			vb_cnt = vb_cnt + 1;
	end

	// ----------------------------------------
	// helpers
	// ----------------------------------------
	task automatic check_val(string name, int exp_v, int got_v);
		chk_cnt = chk_cnt + 1;
		if (exp_v != got_v) begin
			err_cnt = err_cnt + 1;
			$display("Fail t=%0t %s exp=%0h got=%0h", $time, name, exp_v, got_v);
		end
	endtask

	task automatic abort_on_timeout(string what);
		err_cnt = err_cnt + 1;
		$display("Timeout while waiting for %s", what);
		$display("Simulation finished: FAIL");
		$finish;
	endtask

	task automatic reg_write(byte_t a, byte_t d);
		@(posedge clk_reg);
		sel_reg <= 1'b1;
		wr      <= 1'b1;
		addr    <= a;
		di      <= d;
		@(posedge clk_reg);
		sel_reg <= 1'b0;
		wr      <= 1'b0;
	endtask

	// one read per cycle, sampled at the falling edge
	task automatic reg_read(byte_t a, output byte_t v);
		@(posedge clk_reg);
		sel_reg <= 1'b1;
		wr      <= 1'b0;
		addr    <= a;
		@(negedge clk_reg);
		v = dout;
	endtask

	// one LY read per clock, so cycles counts the clocks spent here
	task automatic wait_ly(byte_t target, int limit, output int cycles);
		byte_t v;
		cycles = 1;
		reg_read(ADDR_LY, v);
		while (v != target && cycles < limit) begin
			reg_read(ADDR_LY, v);
			cycles = cycles + 1;
		end
		if (v != target)
			abort_on_timeout($sformatf("LY %0d", target));
	endtask

	task automatic wait_vblank();
		int n;
		n = 0;
		@(negedge clk_reg);
		while (!vblank_irq && n < 2 * LINE_CYCLES * FRAME_LINES) begin
			@(negedge clk_reg);
			n = n + 1;
		end
		if (!vblank_irq)
			abort_on_timeout("vblank_irq");
	endtask

	task automatic report_test(string name, int errs_before);
		if (err_cnt == errs_before)
			$display("test %s: ok", name);
		else
			$display("test %s: errors", name);
	endtask

	// one checked frame with the given setup
	task automatic run_frame(byte_t lcdc, byte_t scx, byte_t scy, byte_t bgp);
		reg_write(ADDR_LCDC, 8'h00);
		reg_write(ADDR_SCX, scx);
		reg_write(ADDR_SCY, scy);
		reg_write(ADDR_BGP, bgp);
		cfg_lcdc = lcdc;
		cfg_scx = scx;
		cfg_scy = scy;
		cfg_bgp = bgp;
		reg_write(ADDR_LCDC, lcdc);
		wait_vblank();
		chk_line = 0;
		chk_col = 0;
		check_on = 1'b1;
		wait_vblank();
		check_on = 1'b0;
		check_val("visible lines", VISIBLE_LINES, chk_line);
	endtask

	// ----------------------------------------
	// stimulus
	// ----------------------------------------
	initial begin
		byte_t v;
		int    c;
		int    e0;
		int    r;
		int    exp_mode;
		clk_reg = 1'b0;
		reset = 1'b1;
		sel_reg = 1'b0;
		wr = 1'b0;
		addr = 8'h00;
		di = 8'h00;
		vram_data = 8'h00;
		check_on = 1'b0;
		prev_clkena = 1'b0;
		err_cnt = 0;
		chk_cnt = 0;
		irq_cnt = 0;
		vb_cnt = 0;
		seed = 99;
		for (int i = 0; i < 8192; i++) begin
			r = $random(seed);
			vram_mem[i] = r[7:0];
		end
		repeat (10) @(posedge clk_reg);
		reset <= 1'b0;

		// register access
		e0 = err_cnt;
		reg_read(ADDR_LCDC, v);
		check_val("LCDC", 8'h00, v);
		reg_read(ADDR_STAT, v);
		check_val("STAT", 8'h84, v);
		reg_read(ADDR_BGP, v);
		check_val("BGP", 8'hFC, v);
		reg_read(ADDR_DMA, v);
		check_val("DMA", 8'hFF, v);
		reg_read(8'h4C, v);
		check_val("unused", 8'hFF, v);
		reg_read(ADDR_SCY, v);
		check_val("SCY", 8'h00, v);
		reg_read(ADDR_SCX, v);
		check_val("SCX", 8'h00, v);
		reg_read(ADDR_LY, v);
		check_val("LY", 8'h00, v);
		reg_read(ADDR_LYC, v);
		check_val("LYC", 8'h00, v);
		reg_read(ADDR_WY, v);
		check_val("WY", 8'h00, v);
		reg_read(ADDR_WX, v);
		check_val("WX", 8'h00, v);
		reg_write(ADDR_LCDC, 8'h35);
		reg_write(ADDR_SCY, 8'h5A);
		reg_write(ADDR_SCX, 8'hA7);
		reg_write(ADDR_LYC, 8'h3C);
		reg_write(ADDR_BGP, 8'h1B);
		reg_write(ADDR_WY, 8'h21);
		reg_write(ADDR_WX, 8'h7F);
		reg_write(ADDR_STAT, 8'h78);
		reg_write(ADDR_LY, 8'h55);
		reg_write(ADDR_DMA, 8'h12);
		reg_read(ADDR_LCDC, v);
		check_val("LCDC", 8'h35, v);
		reg_read(ADDR_SCY, v);
		check_val("SCY", 8'h5A, v);
		reg_read(ADDR_SCX, v);
		check_val("SCX", 8'hA7, v);
		reg_read(ADDR_LYC, v);
		check_val("LYC", 8'h3C, v);
		reg_read(ADDR_BGP, v);
		check_val("BGP", 8'h1B, v);
		reg_read(ADDR_WY, v);
		check_val("WY", 8'h21, v);
		reg_read(ADDR_WX, v);
		check_val("WX", 8'h7F, v);
		reg_read(ADDR_STAT, v);
		check_val("STAT", 8'hF8, v);
		reg_read(ADDR_LY, v);
		check_val("LY", 8'h00, v);
		reg_read(ADDR_DMA, v);
		check_val("DMA", 8'hFF, v);
		reg_write(ADDR_STAT, 8'h00);
		reg_write(ADDR_LYC, 8'h00);
		report_test("register access", e0);

		// display off, then line counting
		e0 = err_cnt;
		for (int i = 0; i < 500; i++) begin
			if (i % 2 == 0) begin
				reg_read(ADDR_LY, v);
				check_val("LY", 0, v);
			end else begin
				reg_read(ADDR_STAT, v);
				check_val("STAT mode", 0, v[1:0]);
			end
			check_val("lcd_clkena", 0, lcd_clkena);
			check_val("lcd_on", 0, lcd_on);
			check_val("mode", 0, mode);
		end
		reg_write(ADDR_LCDC, 8'h91);
		@(negedge clk_reg);
		check_val("lcd_on", 1, lcd_on);
		wait_ly(8'd1, 2 * LINE_CYCLES, c);
		wait_ly(8'd2, 2 * LINE_CYCLES, c);
		check_val("cycles per line", LINE_CYCLES, c);
		wait_ly(8'd153, FRAME_LINES * LINE_CYCLES, c);
		wait_ly(8'd0, 2 * LINE_CYCLES, c);
		report_test("display off", e0);

		// mode sequence, first read lands on h_cnt 1
		e0 = err_cnt;
		wait_ly(8'd5, 10 * LINE_CYCLES, c);
		for (int h = 1; h < LINE_CYCLES; h++) begin
			exp_mode = (h < 80) ? 2 : ((h < 252) ? 3 : 0);
			reg_read(ADDR_STAT, v);
			check_val("STAT mode", exp_mode, v[1:0]);
			check_val("mode", exp_mode, mode);
		end
		wait_ly(8'd144, FRAME_LINES * LINE_CYCLES, c);
		for (int i = 1; i < 10 * LINE_CYCLES; i++) begin
			reg_read(ADDR_STAT, v);
			check_val("STAT mode", 1, v[1:0]);
		end
		report_test("mode sequence", e0);

		// interrupts over one whole frame
		e0 = err_cnt;
		reg_write(ADDR_LYC, 8'd20);
		reg_write(ADDR_STAT, 8'h40);
		wait_ly(8'd153, FRAME_LINES * LINE_CYCLES, c);
		wait_ly(8'd0, 2 * LINE_CYCLES, c);
		irq_cnt = 0;
		vb_cnt = 0;
		for (int i = 1; i < FRAME_LINES * LINE_CYCLES; i++) begin
			reg_read(ADDR_STAT, v);
			check_val("STAT match", (i / LINE_CYCLES == 20) ? 1 : 0, v[2]);
		end
		check_val("irq pulses", 1, irq_cnt);
		check_val("vblank_irq pulses", 1, vb_cnt);
		reg_write(ADDR_STAT, 8'h00);
		report_test("interrupts", e0);

		// pixel output, both tile data modes and both maps
		e0 = err_cnt;
		run_frame(8'h91, 8'h00, 8'h00, 8'hFC);
		run_frame(8'h89, 8'h03, 8'h11, 8'hE4);
		run_frame(8'h81, 8'h85, 8'hF2, 8'h1B);
		run_frame(8'h99, 8'h2E, 8'h09, 8'h93);
		report_test("pixel output", e0);

		// background disabled
		e0 = err_cnt;
		run_frame(8'h90, 8'h05, 8'h30, 8'hE4);
		report_test("background off", e0);

		$display("checks %0d, errors %0d", chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
logic/video_pkg.sv
logic/video_regs.sv
logic/video_timing.sv
logic/bg_fetch.sv
logic/pixel_out.sv
logic/video.sv
bench/video_assertions.sv
bench/video_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= video_tb
FILELIST  ?= files.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
